// ==== design/rtc_pkg.sv ====
// RTC shared package with field widths, register layouts, offsets and the ID value
package rtc_pkg;

	// Field widths.
	typedef logic [5:0]  sec_t;      // Seconds or minutes.
	typedef logic [4:0]  hour_t;
	typedef logic [14:0] day_t;
	typedef logic [3:0]  reg_addr_t; // Word address paddr[5:2].
	typedef logic [31:0] apb_data_t;

	// Counter register layout.
	typedef struct packed {
		day_t  day;  // Bits 31 to 17.
		hour_t hour; // Bits 16 to 12.
		sec_t  min;  // Bits 11 to 6.
		sec_t  sec;  // Bits 5 to 0.
	} rtc_time_t;

	typedef struct packed {
		hour_t hour;
		sec_t  min;
		sec_t  sec;
	} rtc_alarm_t;

	// Rollover strobes from the counter.
	typedef struct packed {
		logic sec;
		logic min;
		logic hour;
		logic day;
	} rtc_event_t;

	// Interrupt flags, also the enable field order.
	typedef struct packed {
		logic sec;
		logic min;
		logic hour;
		logic day;
		logic alarm;
	} rtc_int_t;

	typedef struct packed {
		rtc_int_t int_en; // Bits 6 to 2.
		logic     rsvd;   // Reads as zero.
		logic     rtc_en;
	} rtc_ctrl_t;

	// Register word offsets.
	localparam reg_addr_t REG_ID  = 4'd0;
	localparam reg_addr_t REG_CNT = 4'd4;
	localparam reg_addr_t REG_ALM = 4'd5;
	localparam reg_addr_t REG_CTL = 4'd6;
	localparam reg_addr_t REG_STS = 4'd7;

	localparam apb_data_t RTC_ID = 32'h5254_0100;

	localparam int STS_WDONE_BIT = 16;

endpackage

// ==== design/rtc_tick_gen.sv ====
// RTC prescaler that divides pclk down to a one-cycle seconds tick
`timescale 1ns/10ps

module rtc_tick_gen #(
	parameter int TICK_DIV = 32768
) (
	input  logic pclk,
	input  logic presetn,
	output logic tick
);

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0] div_q;
	logic             div_zero;

	assign div_zero = (div_q == '0);

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			div_q <= RELOAD;
			tick  <= 1'b0;
		end else begin
			tick <= div_zero; // First tick TICK_DIV cycles out of reset.
			if (div_zero) begin
				div_q <= RELOAD;
			end else begin
				div_q <= div_q - 1'b1;
			end
		end
	end

	// A divided tick is a single strobe, never a level.
	generate
		if (TICK_DIV > 1) begin : g_tick_chk
			a_tick_single: assert property (
				@(posedge pclk) disable iff (!presetn)
				tick |=> !tick
			) else $error("tick held high for two cycles");
		end
	endgenerate

endmodule

// ==== design/rtc_time_counter.sv ====
// RTC time counter keeping seconds, minutes, hours and days with rollover events
`timescale 1ns/10ps

module rtc_time_counter (
	input  logic                pclk,
	input  logic                presetn,
	input  logic                tick,
	input  logic                rtc_en,
	input  logic                cnt_load,
	input  rtc_pkg::rtc_time_t  cnt_wdata,
	output rtc_pkg::rtc_time_t  count,
	output rtc_pkg::rtc_event_t events
);

	import rtc_pkg::*;

	logic       sec_wrap;
	logic       min_wrap;
	logic       hour_wrap;
	logic       do_load;
	logic       do_inc;
	rtc_time_t  count_inc;
	rtc_event_t events_inc;

	assign do_load = tick & cnt_load;
	assign do_inc  = tick & rtc_en & ~cnt_load;

	// Carry chain. Out of range loaded values wrap on the next increment.
	always_comb begin
		sec_wrap  = (count.sec >= 6'd59);
		min_wrap  = sec_wrap && (count.min >= 6'd59);
		hour_wrap = min_wrap && (count.hour >= 5'd23);

		count_inc     = count;
		count_inc.sec = sec_wrap ? 6'd0 : count.sec + 6'd1;
		if (sec_wrap) begin
			count_inc.min = min_wrap ? 6'd0 : count.min + 6'd1;
		end
		if (min_wrap) begin
			count_inc.hour = hour_wrap ? 5'd0 : count.hour + 5'd1;
		end
		if (hour_wrap) begin
			count_inc.day = count.day + 15'd1;
		end

		events_inc.sec  = 1'b1;
		events_inc.min  = sec_wrap;
		events_inc.hour = min_wrap;
		events_inc.day  = hour_wrap;
	end

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			count  <= '0;
			events <= '0;
		end else begin
			events <= '0; // Strobes last one cycle.
			if (do_load) begin
				count <= cnt_wdata; // A load raises no events.
			end else if (do_inc) begin
				count  <= count_inc;
				events <= events_inc;
			end
		end
	end

	// Fields stay in their legal range after every increment.
	a_time_range: assert property (
		@(posedge pclk) disable iff (!presetn)
		do_inc |=> (count.sec < 6'd60) && (count.min < 6'd60) && (count.hour < 5'd24)
	) else $error("time field out of range after increment");

endmodule

// ==== design/rtc_alarm_match.sv ====
// RTC alarm register and comparator raising a one-cycle hit per matching second
`timescale 1ns/10ps

module rtc_alarm_match (
	input  logic                pclk,
	input  logic                presetn,
	input  logic                alm_load,
	input  rtc_pkg::rtc_alarm_t alm_wdata,
	input  rtc_pkg::rtc_time_t  count,
	input  logic                sec_event,
	output logic                alarm_hit
);

	import rtc_pkg::*;

	rtc_alarm_t alm_q;
	logic       time_eq;

	// Day is not part of the alarm.
	assign time_eq = (count.hour == alm_q.hour) &&
			 (count.min == alm_q.min) &&
			 (count.sec == alm_q.sec);

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			alm_q <= '0;
		end else if (alm_load) begin
			alm_q <= alm_wdata;
		end
	end

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			alarm_hit <= 1'b0;
		end else begin
			alarm_hit <= sec_event & time_eq; // Once per matching second.
		end
	end

endmodule

// ==== design/rtc_apb_regs.sv ====
// RTC APB register block with shadow registers, tick-staged writes and interrupt flags
`timescale 1ns/10ps

module rtc_apb_regs (
	input  logic                pclk,
	input  logic                presetn,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  rtc_pkg::reg_addr_t  paddr,
	input  rtc_pkg::apb_data_t  pwdata,
	output rtc_pkg::apb_data_t  prdata,
	input  logic                tick,
	input  rtc_pkg::rtc_time_t  count,
	input  rtc_pkg::rtc_event_t events,
	input  logic                alarm_hit,
	output logic                cnt_load,
	output rtc_pkg::rtc_time_t  cnt_wdata,
	output logic                alm_load,
	output rtc_pkg::rtc_alarm_t alm_wdata,
	output logic                rtc_en,
	output rtc_pkg::rtc_int_t   irq
);

	import rtc_pkg::*;

	reg_addr_t  addr_q;
	logic       wr_en;
	logic       wr_cnt;
	logic       wr_alm;
	logic       wr_ctl;
	logic       wr_sts;
	rtc_time_t  cnt_shd;
	rtc_alarm_t alm_shd;
	rtc_ctrl_t  ctl_shd;
	rtc_ctrl_t  ctl_act;
	rtc_ctrl_t  ctl_wr;
	logic       cnt_pend;
	logic       alm_pend;
	logic       ctl_pend;
	logic       wdone;
	rtc_int_t   int_q;
	rtc_int_t   int_set;
	rtc_int_t   int_clr;
	apb_data_t  sts_word;

	// Address is taken in the setup phase.
	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			addr_q <= '0;
		end else if (psel) begin
			addr_q <= paddr;
		end
	end

	assign wr_en  = psel & penable & pwrite;
	assign wr_cnt = wr_en & (addr_q == REG_CNT);
	assign wr_alm = wr_en & (addr_q == REG_ALM);
	assign wr_ctl = wr_en & (addr_q == REG_CTL);
	assign wr_sts = wr_en & (addr_q == REG_STS);

	always_comb begin
		ctl_wr      = pwdata[6:0];
		ctl_wr.rsvd = 1'b0;
	end

	// Shadow registers. The counter shadow follows the count seen at each tick.
	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			cnt_shd <= '0;
			alm_shd <= '0;
			ctl_shd <= '0;
		end else begin
			if (wr_cnt) begin
				cnt_shd <= pwdata;
			end else if (tick && !cnt_pend) begin
				cnt_shd <= count;
			end
			if (wr_alm) begin
				alm_shd <= pwdata[16:0];
			end
			if (wr_ctl) begin
				ctl_shd <= ctl_wr;
			end
		end
	end

	// A write in the tick cycle stays pending for the following tick.
	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			cnt_pend <= 1'b0;
			alm_pend <= 1'b0;
			ctl_pend <= 1'b0;
		end else begin
			if (wr_cnt) begin
				cnt_pend <= 1'b1;
			end else if (tick) begin
				cnt_pend <= 1'b0;
			end
			if (wr_alm) begin
				alm_pend <= 1'b1;
			end else if (tick) begin
				alm_pend <= 1'b0;
			end
			if (wr_ctl) begin
				ctl_pend <= 1'b1;
			end else if (tick) begin
				ctl_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			ctl_act <= '0;
		end else if (tick && ctl_pend) begin
			ctl_act <= ctl_shd;
		end
	end

	assign cnt_load  = tick & cnt_pend;
	assign cnt_wdata = cnt_shd;
	assign alm_load  = tick & alm_pend;
	assign alm_wdata = alm_shd;
	assign rtc_en    = ctl_act.rtc_en;
	assign wdone     = ~(cnt_pend | alm_pend | ctl_pend);

	// Flags set only while counting and enabled.
	assign int_set = {events, alarm_hit} & ctl_act.int_en & {5{ctl_act.rtc_en}};
	assign int_clr = pwdata[6:2] & {5{wr_sts}};

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			int_q <= '0;
		end else begin
			int_q <= (int_q | int_set) & ~int_clr; // Clear wins.
		end
	end

	assign irq = int_q;

	always_comb begin
		sts_word                = '0;
		sts_word[STS_WDONE_BIT] = wdone;
		sts_word[6:2]           = int_q;
		case (addr_q)
			REG_ID:  prdata = RTC_ID;
			REG_CNT: prdata = cnt_shd;
			REG_ALM: prdata = {15'd0, alm_shd};
			REG_CTL: prdata = {25'd0, ctl_shd};
			REG_STS: prdata = sts_word;
			default: prdata = '0;
		endcase
	end

	// A staged write goes out as a single strobe on its tick.
	a_load_on_tick: assert property (
		@(posedge pclk) disable iff (!presetn)
		(cnt_load || alm_load) |=> !(cnt_load || alm_load)
	) else $error("load strobe held past its tick");

endmodule

// ==== design/rtc_top.sv ====
// RTC top level joining the prescaler, time counter, alarm comparator and APB registers
`timescale 1ns/10ps

module rtc_top #(
	parameter int TICK_DIV = 32768
) (
	input  logic               pclk,
	input  logic               presetn,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  rtc_pkg::reg_addr_t paddr,
	input  rtc_pkg::apb_data_t pwdata,
	output rtc_pkg::apb_data_t prdata,
	output rtc_pkg::rtc_int_t  irq
);

	import rtc_pkg::*;

	logic       tick;
	logic       cnt_load;
	logic       alm_load;
	logic       rtc_en;
	logic       alarm_hit;
	rtc_time_t  count;
	rtc_time_t  cnt_wdata;
	rtc_alarm_t alm_wdata;
	rtc_event_t events;

	rtc_tick_gen #(
		.TICK_DIV (TICK_DIV)
	) u_tick (
		.pclk    (pclk),
		.presetn (presetn),
		.tick    (tick)
	);

	rtc_time_counter u_counter (
		.pclk      (pclk),
		.presetn   (presetn),
		.tick      (tick),
		.rtc_en    (rtc_en),
		.cnt_load  (cnt_load),
		.cnt_wdata (cnt_wdata),
		.count     (count),
		.events    (events)
	);

	rtc_alarm_match u_alarm (
		.pclk      (pclk),
		.presetn   (presetn),
		.alm_load  (alm_load),
		.alm_wdata (alm_wdata),
		.count     (count),
		.sec_event (events.sec),
		.alarm_hit (alarm_hit)
	);

	rtc_apb_regs u_regs (
		.pclk      (pclk),
		.presetn   (presetn),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.tick      (tick),
		.count     (count),
		.events    (events),
		.alarm_hit (alarm_hit),
		.cnt_load  (cnt_load),
		.cnt_wdata (cnt_wdata),
		.alm_load  (alm_load),
		.alm_wdata (alm_wdata),
		.rtc_en    (rtc_en),
		.irq       (irq)
	);

endmodule

// ==== test/rtc_clk_gen.sv ====
// RTC testbench clock and reset source
`timescale 1ns/10ps

module rtc_clk_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 16
) (
	output logic pclk,
	output logic presetn
);

	initial begin
		pclk = 1'b0;
		forever begin
			#(PERIOD / 2) pclk = ~pclk;
		end
	end

	initial begin
		presetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge pclk);
		presetn <= 1'b1; // Released on a rising edge.
	end

endmodule

// ==== test/rtc_tb.sv ====
// RTC testbench applying a table of APB operations and checking time, status and irq
`timescale 1ns/10ps

module rtc_tb;

	import rtc_pkg::*;

	localparam int TICK_DIV     = 16;
	localparam int RESET_CYCLES = 16;

	localparam logic [3:0] OP_WR   = 4'd0; // Write a register.
	localparam logic [3:0] OP_RD   = 4'd1; // Read and compare.
	localparam logic [3:0] OP_STS  = 4'd2; // Read status and check irq against it.
	localparam logic [3:0] OP_POLL = 4'd3; // Poll status until the mask is set.
	localparam logic [3:0] OP_CLR  = 4'd4; // Write one to clear flags.
	localparam logic [3:0] OP_CNT  = 4'd5; // Compare CNT with the time model.
	localparam logic [3:0] OP_SNAP = 4'd6;
	localparam logic [3:0] OP_SAME = 4'd7;
	localparam logic [3:0] OP_WAIT = 4'd8;

	localparam apb_data_t WDONE  = 32'h1 << STS_WDONE_BIT;
	localparam apb_data_t F_SEC  = 32'h40; // Flag and enable bits share positions.
	localparam apb_data_t F_MIN  = 32'h20;
	localparam apb_data_t F_HOUR = 32'h10;
	localparam apb_data_t F_DAY  = 32'h08;
	localparam apb_data_t F_ALM  = 32'h04;
	localparam apb_data_t F_ALL  = 32'h7c;
	localparam apb_data_t EN     = 32'h01;

	typedef struct packed {
		logic [3:0] op;
		reg_addr_t  addr;
		apb_data_t  data;
		apb_data_t  exp;
		logic       rnd;
	} row_t;

	logic      pclk;
	logic      presetn;
	logic      psel;
	logic      penable;
	logic      pwrite;
	reg_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	rtc_int_t  irq;
	rtc_int_t  irq_at_read;
	row_t      rows[$];
	rtc_time_t model;
	rtc_time_t snap;
	apb_data_t last_rnd;
	logic [31:0] lcg_state;
	int        cycles;
	int        limit;
	int        errors;

	rtc_clk_gen #(
		.PERIOD       (100),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clk (
		.pclk    (pclk),
		.presetn (presetn)
	);

	rtc_top #(
		.TICK_DIV (TICK_DIV)
	) u_dut (
		.pclk    (pclk),
		.presetn (presetn),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.irq     (irq)
	);

	function automatic rtc_time_t make_time(int d, int h, int m, int s);
		rtc_time_t t;
		t.day  = day_t'(d);
		t.hour = hour_t'(h);
		t.min  = sec_t'(m);
		t.sec  = sec_t'(s);
		return t;
	endfunction

	function automatic apb_data_t alarm_word(int h, int m, int s);
		rtc_alarm_t a;
		a.hour = hour_t'(h);
		a.min  = sec_t'(m);
		a.sec  = sec_t'(s);
		return {15'd0, a};
	endfunction

	// Reference clock arithmetic, one second forward.
	function automatic rtc_time_t next_second(rtc_time_t t);
		rtc_time_t n;
		n = t;
		if (t.sec == 6'd59) begin
			n.sec = 6'd0;
			if (t.min == 6'd59) begin
				n.min = 6'd0;
				if (t.hour == 5'd23) begin
					n.hour = 5'd0;
					n.day  = t.day + 1'b1;
				end else begin
					n.hour = t.hour + 1'b1;
				end
			end else begin
				n.min = t.min + 1'b1;
			end
		end else begin
			n.sec = t.sec + 1'b1;
		end
		return n;
	endfunction

	function apb_data_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped.");
	endtask

	task automatic check_data(string name, apb_data_t got, apb_data_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_time(string name, rtc_time_t got, rtc_time_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_int(string name, rtc_int_t got, rtc_int_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic add_row(logic [3:0] op, reg_addr_t addr, apb_data_t data, apb_data_t exp,
			       logic rnd = 1'b0);
		row_t r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		r.rnd  = rnd;
		rows.push_back(r);
	endtask

	task automatic apb_write(reg_addr_t addr, apb_data_t data);
		@(posedge pclk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge pclk);
		penable <= 1'b1;
		@(posedge pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(reg_addr_t addr, output apb_data_t data);
		@(posedge pclk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge pclk);
		penable <= 1'b1;
		@(negedge pclk);
		data        = prdata; // Mid access phase.
		irq_at_read = irq;
		@(posedge pclk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_status(apb_data_t exp);
		apb_data_t d;
		apb_read(REG_STS, d);
		check_data("prdata STS", d, exp);
		check_int("irq", irq_at_read, exp[6:2]);
	endtask

	task automatic poll_status(apb_data_t mask);
		apb_data_t d;
		int        waited;
		waited = 0;
		d      = '0;
		while ((d & mask) != mask) begin
			if (waited > TICK_DIV + 4) begin
				$display("Status poll gave up waiting for mask 0x%h", mask);
				stop_run();
			end else begin
				apb_read(REG_STS, d);
				waited += 3;
			end
		end
	endtask

	task automatic run_row(row_t r);
		apb_data_t d;
		apb_data_t wdata;
		case (r.op)
			OP_WR: begin
				wdata = r.data;
				if (r.rnd) begin
					wdata    = lcg_next();
					last_rnd = wdata;
				end
				if (r.addr == REG_CNT) begin
					model = wdata;
				end
				apb_write(r.addr, wdata);
			end
			OP_RD: begin
				apb_read(r.addr, d);
				check_data("prdata", d, r.rnd ? (last_rnd & r.exp) : r.exp);
			end
			OP_STS:  check_status(r.exp);
			OP_POLL: poll_status(r.data);
			OP_CLR:  apb_write(REG_STS, r.data);
			OP_CNT: begin
				apb_read(REG_CNT, d);
				check_time("prdata CNT", d, model);
				model = next_second(model); // Shadow trails the counter by one tick.
			end
			OP_SNAP: begin
				apb_read(REG_CNT, d);
				snap = d;
			end
			OP_SAME: begin
				apb_read(REG_CNT, d);
				check_time("prdata CNT", d, snap);
			end
			OP_WAIT: repeat (r.data) @(posedge pclk);
			default: begin
				$display("Table row holds an unknown operation %0d", r.op);
				stop_run();
			end
		endcase
	endtask

	task automatic build_table();
		// Reset state.
		add_row(OP_RD, REG_ID, 0, RTC_ID);
		add_row(OP_RD, REG_CNT, 0, 0);
		add_row(OP_RD, REG_ALM, 0, 0);
		add_row(OP_RD, REG_CTL, 0, 0);
		add_row(OP_STS, REG_STS, 0, WDONE);
		// Staged alarm write, the first pair lines up with a tick.
		add_row(OP_WR, REG_ALM, 0, 0);
		add_row(OP_POLL, REG_STS, WDONE, 0);
		add_row(OP_WR, REG_ALM, 0, 0, 1'b1);
		add_row(OP_STS, REG_STS, 0, 0);
		add_row(OP_RD, REG_ALM, 0, 32'h1_ffff, 1'b1);
		add_row(OP_POLL, REG_STS, WDONE, 0);
		// Day rollover with every enable on.
		add_row(OP_WR, REG_ALM, alarm_word(12, 34, 56), 0);
		add_row(OP_POLL, REG_STS, WDONE, 0);
		add_row(OP_WR, REG_CNT, make_time(4, 23, 59, 58), 0);
		add_row(OP_WR, REG_CTL, EN | F_ALL, 0);
		add_row(OP_POLL, REG_STS, WDONE, 0);
		add_row(OP_POLL, REG_STS, F_SEC, 0);
		add_row(OP_STS, REG_STS, 0, WDONE | F_SEC);
		add_row(OP_CLR, REG_STS, F_SEC, 0);
		add_row(OP_CNT, REG_CNT, 0, 0);
		for (int i = 0; i < 2; i++) begin
			add_row(OP_POLL, REG_STS, F_SEC, 0);
			add_row(OP_STS, REG_STS, 0, WDONE | F_SEC | F_MIN | F_HOUR | F_DAY);
			add_row(OP_CLR, REG_STS, F_SEC, 0);
			add_row(OP_CNT, REG_CNT, 0, 0);
		end
		// Seconds enable only, across a minute wrap.
		add_row(OP_POLL, REG_STS, F_SEC, 0);
		add_row(OP_WR, REG_CNT, make_time(5, 0, 0, 58), 0);
		add_row(OP_WR, REG_CTL, EN | F_SEC, 0);
		add_row(OP_POLL, REG_STS, WDONE, 0);
		add_row(OP_CLR, REG_STS, F_HOUR, 0);
		add_row(OP_STS, REG_STS, 0, WDONE | F_SEC | F_MIN | F_DAY);
		add_row(OP_CLR, REG_STS, F_ALL, 0);
		add_row(OP_STS, REG_STS, 0, WDONE);
		add_row(OP_POLL, REG_STS, F_SEC, 0);
		add_row(OP_CLR, REG_STS, F_SEC, 0);
		add_row(OP_POLL, REG_STS, F_SEC, 0);
		add_row(OP_CLR, REG_STS, F_SEC, 0);
		// Alarm two seconds past 00:01:00.
		add_row(OP_WR, REG_ALM, alarm_word(0, 1, 2), 0);
		add_row(OP_WR, REG_CTL, EN | F_SEC | F_ALM, 0);
		add_row(OP_STS, REG_STS, 0, 0);
		add_row(OP_POLL, REG_STS, F_SEC, 0);
		add_row(OP_STS, REG_STS, 0, WDONE | F_SEC);
		add_row(OP_CLR, REG_STS, F_SEC, 0);
		add_row(OP_POLL, REG_STS, F_SEC, 0);
		add_row(OP_STS, REG_STS, 0, WDONE | F_SEC | F_ALM);
		// Counter stopped.
		add_row(OP_CLR, REG_STS, F_ALL, 0);
		add_row(OP_WR, REG_CTL, F_ALL, 0);
		add_row(OP_POLL, REG_STS, WDONE, 0);
		add_row(OP_WAIT, REG_STS, TICK_DIV, 0);
		add_row(OP_SNAP, REG_CNT, 0, 0);
		add_row(OP_WAIT, REG_STS, 3 * TICK_DIV, 0);
		add_row(OP_SAME, REG_CNT, 0, 0);
		add_row(OP_STS, REG_STS, 0, WDONE);
	endtask

	always @(posedge pclk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Run exceeded its limit of %0d cycles", limit);
			stop_run();
		end
	end

	initial begin
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		irq_at_read = '0;
		model       = '0;
		snap        = '0;
		last_rnd    = '0;
		lcg_state   = 32'hd55bdf97;
		errors      = 0;
		cycles      = 0;
		limit       = 0;
		build_table();
		limit = rows.size() * 4 * TICK_DIV + RESET_CYCLES;
		wait (presetn === 1'b1);
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		if (errors == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// ==== all.f ====
design/rtc_pkg.sv
design/rtc_tick_gen.sv
design/rtc_time_counter.sv
design/rtc_alarm_match.sv
design/rtc_apb_regs.sv
design/rtc_top.sv
test/rtc_clk_gen.sv
test/rtc_tb.sv

// ==== Bender.yml ====
package:
  name: rtc

sources:
  - files:
      - design/rtc_pkg.sv
      - design/rtc_tick_gen.sv
      - design/rtc_time_counter.sv
      - design/rtc_alarm_match.sv
      - design/rtc_apb_regs.sv
      - design/rtc_top.sv
  - target: test
    files:
      - test/rtc_clk_gen.sv
      - test/rtc_tb.sv
